/* source/mod_exp_pkg.sv */
`default_nettype none

package mod_exp_pkg;

    // default operand width, the top level passes its own value down
    parameter int OPERAND_W = 32;

    // default number of jobs waiting in front of the controller
    parameter int JOB_DEPTH_DEF = 2;

    // base, exponent, modulus, r2 or result
    typedef logic [OPERAND_W-1:0] operand_t;

    // montgomery running sum, two bits of headroom
    typedef logic [OPERAND_W+1:0] mont_acc_t;

    // base below modulus, modulus odd and >= 3
    // r2 is 2^(2*OPERAND_W) mod modulus
    typedef struct packed {
        operand_t base;
        operand_t expo;
        operand_t modulus;
        operand_t r2;
    } exp_job_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_ONE,
        LOAD_BASE,
        SQUARE,
        MULTIPLY,
        FROM_MONT,
        DONE
    } exp_state_e;

endpackage

`default_nettype wire

/* source/job_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module job_queue import mod_exp_pkg::*; #(
    parameter int OPERAND_W = mod_exp_pkg::OPERAND_W,
    parameter int JOB_DEPTH = JOB_DEPTH_DEF
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     job_valid,
    input  exp_job_t job_in,
    input  logic     pop,
    output logic     head_valid,
    output exp_job_t head_job
);

    localparam int PTR_W = (JOB_DEPTH > 1) ? $clog2(JOB_DEPTH) : 1;
    localparam int CNT_W = $clog2(JOB_DEPTH + 1);

    // job fields are sized by the package
    if (OPERAND_W != $bits(operand_t)) begin : g_width_check
        $error("job_queue: OPERAND_W does not match operand_t");
    end

    exp_job_t         mem [JOB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // first-word-fall-through head
    assign head_valid = (count != '0);
    assign head_job   = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (job_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(JOB_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(JOB_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (job_valid && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !job_valid) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid) begin
            mem[wr_ptr] <= job_in;
        end
    end

    // source pushed without a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        job_valid |-> (count != CNT_W'(JOB_DEPTH)))
        else $error("job_queue: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid)
        else $error("job_queue: pop while empty");

endmodule

`default_nettype wire

/* source/mont_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module mont_mul import mod_exp_pkg::*; #(
    parameter int OPERAND_W = mod_exp_pkg::OPERAND_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mul_start,
    input  operand_t operand_a,
    input  operand_t operand_b,
    input  operand_t modulus,
    output logic     mul_done,
    output operand_t mul_result
);

    localparam int CNT_W = $clog2(OPERAND_W + 1);

    logic             busy;
    logic [CNT_W-1:0] step_cnt;
    logic             done_q;
    logic             shifting;
    operand_t         a_sh;
    mont_acc_t        acc;
    mont_acc_t        acc_add_b;
    mont_acc_t        acc_add_m;
    mont_acc_t        acc_next;
    mont_acc_t        acc_minus_m;
    operand_t         result_q;

    assign shifting   = busy && (step_cnt != '0);
    assign mul_done   = done_q;
    assign mul_result = result_q;

    // one radix-2 step: add b on the a bit, add m to make it even, halve
    always_comb begin
        acc_add_b   = acc + (a_sh[0] ? mont_acc_t'(operand_b) : '0);
        acc_add_m   = acc_add_b + (acc_add_b[0] ? mont_acc_t'(modulus) : '0);
        acc_next    = acc_add_m >> 1;
        acc_minus_m = acc - mont_acc_t'(modulus);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (mul_start) begin
                busy     <= 1'b1;
                step_cnt <= CNT_W'(OPERAND_W);
            end else if (shifting) begin
                step_cnt <= step_cnt - CNT_W'(1);
            end else if (busy) begin
                // final subtraction cycle
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_sh <= operand_a;
            acc  <= '0;
        end else if (shifting) begin
            a_sh <= a_sh >> 1;
            acc  <= acc_next;
        end else if (busy) begin
            // sum is below 2m here, one subtraction is enough
            result_q <= (acc >= mont_acc_t'(modulus)) ? acc_minus_m[OPERAND_W-1:0]
                                                      : acc[OPERAND_W-1:0];
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> !busy)
        else $error("mont_mul: start while a multiplication runs");

    a_odd_modulus: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |-> modulus[0])
        else $error("mont_mul: even modulus at start");

endmodule

`default_nettype wire

/* source/exp_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module exp_ctrl import mod_exp_pkg::*; #(
    parameter int OPERAND_W = mod_exp_pkg::OPERAND_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     head_valid,
    input  exp_job_t head_job,
    output logic     pop,
    output logic     mul_start,
    output operand_t operand_a,
    output operand_t operand_b,
    output operand_t modulus,
    input  logic     mul_done,
    input  operand_t mul_result,
    output logic     result_valid,
    output operand_t result
);

    localparam int CNT_W = $clog2(OPERAND_W + 1);

    exp_state_e       state;
    logic [CNT_W-1:0] bit_cnt;
    logic             mul_start_q;
    logic             last_bit;
    logic             bit_step;
    operand_t         base_q;
    operand_t         expo_sh;
    operand_t         mod_q;
    operand_t         r2_q;
    operand_t         acc_q;
    operand_t         base_m_q;
    operand_t         result_q;

    assign pop          = (state == IDLE) && head_valid;
    assign mul_start    = mul_start_q;
    assign modulus      = mod_q;
    assign result_valid = (state == DONE);
    assign result       = result_q;
    assign last_bit     = (bit_cnt == CNT_W'(1));

    // current exponent bit is finished
    assign bit_step = mul_done &&
                      (((state == SQUARE) && !expo_sh[OPERAND_W-1]) || (state == MULTIPLY));

    //----------------------------------------------------------------------
    // operand select, held until mul_done since state and regs are stable
    //----------------------------------------------------------------------
    always_comb begin
        operand_a = acc_q;
        operand_b = acc_q;
        case (state)
            LOAD_ONE: begin
                operand_a = r2_q;
                operand_b = operand_t'(1);
            end
            LOAD_BASE: begin
                operand_a = base_q;
                operand_b = r2_q;
            end
            MULTIPLY:  operand_b = base_m_q;
            FROM_MONT: operand_b = operand_t'(1);
            default: begin
            end
        endcase
    end

    //----------------------------------------------------------------------
    // square-and-multiply sequencing
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            mul_start_q <= 1'b0;
        end else begin
            mul_start_q <= 1'b0;
            if (bit_step) begin
                bit_cnt <= bit_cnt - CNT_W'(1);
            end
            case (state)
                IDLE: begin
                    if (head_valid) begin
                        state       <= LOAD_ONE;
                        bit_cnt     <= CNT_W'(OPERAND_W);
                        mul_start_q <= 1'b1;
                    end
                end
                LOAD_ONE: begin
                    if (mul_done) begin
                        state       <= LOAD_BASE;
                        mul_start_q <= 1'b1;
                    end
                end
                LOAD_BASE: begin
                    if (mul_done) begin
                        state       <= SQUARE;
                        mul_start_q <= 1'b1;
                    end
                end
                SQUARE: begin
                    if (mul_done) begin
                        mul_start_q <= 1'b1;
                        if (expo_sh[OPERAND_W-1]) begin
                            state <= MULTIPLY;
                        end else if (last_bit) begin
                            state <= FROM_MONT;
                        end
                    end
                end
                MULTIPLY: begin
                    if (mul_done) begin
                        mul_start_q <= 1'b1;
                        state       <= last_bit ? FROM_MONT : SQUARE;
                    end
                end
                FROM_MONT: begin
                    if (mul_done) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            base_q  <= head_job.base;
            expo_sh <= head_job.expo;
            mod_q   <= head_job.modulus;
            r2_q    <= head_job.r2;
        end else if (bit_step) begin
            expo_sh <= expo_sh << 1;
        end
        if (mul_done) begin
            case (state)
                LOAD_ONE, SQUARE, MULTIPLY: acc_q <= mul_result;
                LOAD_BASE:                  base_m_q <= mul_result;
                FROM_MONT:                  result_q <= mul_result;
                default: begin
                end
            endcase
        end
    end

    a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> (state inside {LOAD_ONE, LOAD_BASE, SQUARE, MULTIPLY, FROM_MONT}))
        else $error("exp_ctrl: mul_done in a state that does not wait for it");

endmodule

`default_nettype wire

/* source/mod_exp_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mod_exp_top import mod_exp_pkg::*; #(
    parameter int OPERAND_W = mod_exp_pkg::OPERAND_W,
    parameter int JOB_DEPTH = JOB_DEPTH_DEF
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     job_valid,
    input  exp_job_t job_in,
    output logic     credit_return,
    output logic     result_valid,
    output operand_t result
);

    logic     head_valid;
    exp_job_t head_job;
    logic     pop;
    logic     mul_start;
    logic     mul_done;
    operand_t operand_a;
    operand_t operand_b;
    operand_t modulus;
    operand_t mul_result;

    // a job leaving the queue frees one slot at the source
    assign credit_return = pop;

    job_queue #(
        .OPERAND_W (OPERAND_W),
        .JOB_DEPTH (JOB_DEPTH)
    ) u_job_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .job_valid  (job_valid),
        .job_in     (job_in),
        .pop        (pop),
        .head_valid (head_valid),
        .head_job   (head_job)
    );

    exp_ctrl #(
        .OPERAND_W (OPERAND_W)
    ) u_exp_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head_job     (head_job),
        .pop          (pop),
        .mul_start    (mul_start),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .modulus      (modulus),
        .mul_done     (mul_done),
        .mul_result   (mul_result),
        .result_valid (result_valid),
        .result       (result)
    );

    mont_mul #(
        .OPERAND_W (OPERAND_W)
    ) u_mont_mul (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_start  (mul_start),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .modulus    (modulus),
        .mul_done   (mul_done),
        .mul_result (mul_result)
    );

endmodule

`default_nettype wire

/* test/mod_exp_ref.svh */
`ifndef MOD_EXP_REF_SVH
`define MOD_EXP_REF_SVH

// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------

// plain modular power, right-to-left binary, double-width products
function automatic operand_t mod_pow(input operand_t b, input operand_t e, input operand_t m);
    logic [2*OPERAND_W-1:0] acc;
    logic [2*OPERAND_W-1:0] sq;
    operand_t               ex;
    acc = 1;
    acc = acc % m;
    sq  = b;
    sq  = sq % m;
    ex  = e;
    for (int i = 0; i < OPERAND_W; i++) begin
        if (ex[0]) begin
            acc = (acc * sq) % m;
        end
        sq = (sq * sq) % m;
        ex = ex >> 1;
    end
    return acc[OPERAND_W-1:0];
endfunction

// 2^(2*OPERAND_W) mod m by doubling
function automatic operand_t calc_r2(input operand_t m);
    logic [OPERAND_W:0] r;
    r = 1;
    for (int i = 0; i < 2*OPERAND_W; i++) begin
        r = r << 1;
        if (r >= {1'b0, m}) begin
            r = r - {1'b0, m};
        end
    end
    return r[OPERAND_W-1:0];
endfunction

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

task automatic check_result(input string name, input operand_t expected, input operand_t actual);
    if (expected !== actual) begin
        $display("ERR %s: expected %h, actual %h", name, expected, actual);
        stop_on_failure();
    end
endtask

task automatic check_credits(input string name, input int expected, input int actual);
    if (expected !== actual) begin
        $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
        stop_on_failure();
    end
endtask

`endif

/* test/tb_mod_exp.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mod_exp
    import mod_exp_pkg::*;
();

    localparam int    JOB_DEPTH  = JOB_DEPTH_DEF;
    localparam int    CLK_PERIOD = 40;
    localparam int    NUM_RANDOM = 40;
    // fixed, edge, random and reset groups
    localparam int    NUM_JOBS   = 4 + 3 + NUM_RANDOM + 4;
    localparam longint WATCHDOG_CYCLES = (2*OPERAND_W + 4) * (OPERAND_W + 3) * NUM_JOBS;

    logic     clk;
    logic     rst_n;
    logic     job_valid;
    exp_job_t job_in;
    logic     credit_return;
    logic     result_valid;
    operand_t result;

    int       credits = JOB_DEPTH;
    int       returned_cnt = 0;
    int       pushed_cnt;
    integer   seed = 37955;
    operand_t exp_q[$];
    string    name_q[$];

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    `include "mod_exp_ref.svh"

    mod_exp_top #(
        .OPERAND_W (OPERAND_W),
        .JOB_DEPTH (JOB_DEPTH)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .job_valid     (job_valid),
        .job_in        (job_in),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ------------------------------------------------------------------
    // credit tracking and result checking
    // ------------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits      <= JOB_DEPTH;
            returned_cnt <= 0;
        end else if (credits - int'(job_valid) + int'(credit_return) > JOB_DEPTH) begin
            $display("credit_return pulsed with no job left in the queue");
            stop_on_failure();
        end else begin
            credits <= credits - int'(job_valid) + int'(credit_return);
            if (credit_return) begin
                returned_cnt <= returned_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result_valid seen with no job outstanding");
                stop_on_failure();
            end else begin
                check_result(name_q.pop_front(), exp_q.pop_front(), result);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, results stopped arriving");
        stop_on_failure();
    end

    // ------------------------------------------------------------------
    // stimulus helpers called on a falling edge
    // ------------------------------------------------------------------
    task automatic push_job(input string name, input operand_t b, input operand_t e,
                            input operand_t m);
        exp_job_t job;
        job.base    = b;
        job.expo    = e;
        job.modulus = m;
        job.r2      = calc_r2(m);
        while (credits == 0) begin
            @(negedge clk);
        end
        job_valid = 1'b1;
        job_in    = job;
        exp_q.push_back(mod_pow(b, e, m));
        name_q.push_back(name);
        pushed_cnt++;
        @(negedge clk);
        job_valid = 1'b0;
    endtask

    task automatic drain_and_check(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        check_credits({name, "_credits"}, JOB_DEPTH, credits);
        check_credits({name, "_returns"}, pushed_cnt, returned_cnt);
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        job_valid = 1'b0;
        exp_q.delete();
        name_q.delete();
        pushed_cnt = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        operand_t m;
        operand_t b;
        operand_t e;
        clk        = 1'b0;
        rst_n      = 1'b0;
        job_valid  = 1'b0;
        job_in     = '0;
        pushed_cnt = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // small and large known jobs
        push_job("fixed_3_5_7", 32'd3, 32'd5, 32'd7);
        push_job("fixed_2_10_1001", 32'd2, 32'd10, 32'd1001);
        push_job("fixed_large_a", 32'h1234_5678, 32'hDEAD_BEEF, 32'hFFFF_FFFB);
        push_job("fixed_large_b", 32'hFFFF_FFF0, 32'd65537, 32'hFFFF_FFFD);
        drain_and_check("fixed");

        // exponent corners
        push_job("expo_zero", 32'd12345, 32'h0000_0000, 32'hFFFF_FFC5);
        push_job("expo_all_ones", 32'd7, 32'hFFFF_FFFF, 32'hFFFF_FFFB);
        push_job("expo_top_bit", 32'h0000_ABCD, 32'h8000_0000, 32'hF0F0_F0F1);
        drain_and_check("edge");

        // random stream pushed as fast as credits allow
        for (int i = 0; i < NUM_RANDOM; i++) begin
            m    = $random(seed);
            m[0] = 1'b1;
            if (m < 3) begin
                m = 3;
            end
            b = $random(seed);
            b = b % m;
            e = $random(seed);
            push_job("random", b, e, m);
        end
        drain_and_check("random");

        // reset while one job computes and two wait
        push_job("reset_lost_a", 32'd5, 32'hFFFF_0000, 32'hFFFF_FFFB);
        push_job("reset_lost_b", 32'd6, 32'h0F0F_0F0F, 32'hFFFF_FFFB);
        push_job("reset_lost_c", 32'd7, 32'h1234_5678, 32'hFFFF_FFFB);
        repeat (50) @(negedge clk);
        apply_reset();
        repeat (200) @(negedge clk);
        check_credits("reset_credits", JOB_DEPTH, credits);
        check_credits("reset_returns", 0, returned_cnt);
        push_job("after_reset", 32'h0BAD_F00D, 32'h7654_3210, 32'hFFFF_FFC5);
        drain_and_check("after_reset");

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+test
source/mod_exp_pkg.sv
source/job_queue.sv
source/mont_mul.sv
source/exp_ctrl.sv
source/mod_exp_top.sv
test/tb_mod_exp.sv

/* Bender.yml */
package:
  name: mod_exp

sources:
  - files:
      - source/mod_exp_pkg.sv
      - source/job_queue.sv
      - source/mont_mul.sv
      - source/exp_ctrl.sv
      - source/mod_exp_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mod_exp.sv
